/* hdl/tmr_rx_cfg.svh */
`ifndef TMR_RX_CFG_SVH
`define TMR_RX_CFG_SVH

// ======================================================================
// sizes of the triple redundant receive path
// ======================================================================

// byte index of the copy id, counted from the first rx_en byte
`define TMR_ID_OFFSET 22

// width of buffer addresses and payload lengths
`define TMR_ADDR_W 8

// longest payload kept per copy
// anything beyond is cut and the set is lost
`define TMR_MAX_LEN 200

`endif

/* hdl/tmr_rx_pkg.sv */
package tmr_rx_pkg;

	// where the producer stands within a set of three copies
	typedef enum logic [1:0] {
		SEQ_IDLE   = 2'd0, // no copy held
		SEQ_HAVE1  = 2'd1, // copy 1 stored
		SEQ_HAVE12 = 2'd2  // copies 1 and 2 stored
	} seq_state_e;

	// agreement of the three copies at one byte position
	typedef enum logic [1:0] {
		VOTE_ALL  = 2'd0, // all equal
		VOTE_MAJ  = 2'd1, // two of three equal
		VOTE_NONE = 2'd2  // all differ, copy 1 sent
	} vote_e;

endpackage

/* hdl/copy_capture.sv */
`timescale 1ns/1ps
`include "tmr_rx_cfg.svh"

module copy_capture import tmr_rx_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   rx_en,
	input  logic [7:0]             rx_data,
	input  logic                   busy,
	output logic                   wr_en,
	output logic [1:0]             wr_copy,
	output logic [`TMR_ADDR_W-1:0] wr_addr,
	output logic [7:0]             wr_data,
	output logic                   len_we,
	output logic [1:0]             len_copy,
	output logic [`TMR_ADDR_W-1:0] len_val,
	output logic                   set_ready,
	output logic                   lost
);

	localparam int AW = `TMR_ADDR_W;
	localparam logic [AW-1:0] ID_OFF  = AW'(`TMR_ID_OFFSET);
	localparam logic [AW-1:0] MAX_LEN = AW'(`TMR_MAX_LEN);

	logic          rx_en_q;   // input register
	logic          rx_en_d;   // one more stage, for the end check
	logic [7:0]    rx_data_q;

	logic [AW-1:0] hdr_cnt;   // header byte index
	logic          in_pay;    // id seen, payload follows
	logic [3:0]    id_q;
	logic          blk_q;     // no writes for this packet
	logic [AW-1:0] pay_cnt;   // payload bytes kept
	logic          trunc_q;   // payload ran past MAX_LEN
	logic          drop_set;  // rest of a dropped set is skipped
	logic [AW-1:0] len1_q;    // length of copy 1 in this set

	seq_state_e    state;
	seq_state_e    next_state;

	logic          id_ok;
	logic          pay_full;
	logic          end_pkt;
	logic          has_pay;
	logic          seq_ok;
	logic          drop_nxt;
	logic          ready_c;
	logic          lost_c;

	// ==================================================================
	// input register and byte counting
	// ==================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_en_q <= 1'b0;
			rx_en_d <= 1'b0;
		end else begin
			rx_en_q <= rx_en;
			rx_en_d <= rx_en_q;
		end
	end

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
	end

	assign id_ok    = (id_q >= 4'd1) && (id_q <= 4'd3);
	assign pay_full = (pay_cnt == MAX_LEN);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hdr_cnt <= '0;
			in_pay  <= 1'b0;
			id_q    <= '0;
			blk_q   <= 1'b0;
			pay_cnt <= '0;
			trunc_q <= 1'b0;
		end else if (!rx_en_q) begin
			// between packets
			hdr_cnt <= '0;
			in_pay  <= 1'b0;
			pay_cnt <= '0;
			trunc_q <= 1'b0;
		end else if (!in_pay) begin
			if (hdr_cnt == ID_OFF) begin
				id_q   <= rx_data_q[3:0];
				in_pay <= 1'b1;
				// copy 1 under busy, or the tail of a dropped set
				blk_q  <= busy || (drop_set && rx_data_q[3:0] != 4'd1);
			end else begin
				hdr_cnt <= hdr_cnt + 1'b1;
			end
		end else if (pay_full) begin
			trunc_q <= 1'b1; // extra bytes are cut
		end else begin
			pay_cnt <= pay_cnt + 1'b1;
		end
	end

	assign wr_en   = rx_en_q && in_pay && id_ok && !blk_q && !pay_full;
	assign wr_copy = id_q[1:0];
	assign wr_addr = pay_cnt;
	assign wr_data = rx_data_q;

	// ==================================================================
	// set sequence
	// ==================================================================

	assign end_pkt = rx_en_d && !rx_en_q;
	assign has_pay = in_pay && id_ok && (pay_cnt != '0);

	// copy 2 or 3 fits the set only in order and at the copy 1 length
	assign seq_ok = !blk_q && !trunc_q && (pay_cnt == len1_q) &&
		((id_q == 4'd2 && state == SEQ_HAVE1) ||
		 (id_q == 4'd3 && state == SEQ_HAVE12));

	assign len_copy = id_q[1:0];
	assign len_val  = pay_cnt;

	always_comb begin
		next_state = state;
		drop_nxt   = drop_set;
		ready_c    = 1'b0;
		lost_c     = 1'b0;
		len_we     = 1'b0;
		if (end_pkt && has_pay) begin
			if (id_q == 4'd1) begin
				if (blk_q) begin // previous set still sending
					lost_c     = 1'b1;
					drop_nxt   = 1'b1;
					next_state = SEQ_IDLE;
				end else begin
					drop_nxt   = 1'b0;
					lost_c     = (state != SEQ_IDLE) || trunc_q;
					len_we     = !trunc_q;
					next_state = trunc_q ? SEQ_IDLE : SEQ_HAVE1;
				end
			end else if (!drop_set) begin
				if (seq_ok) begin
					len_we = 1'b1;
					if (id_q == 4'd2) begin
						next_state = SEQ_HAVE12;
					end else begin
						next_state = SEQ_IDLE;
						ready_c    = 1'b1; // full set in the store
					end
				end else begin
					lost_c     = 1'b1;
					next_state = SEQ_IDLE;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= SEQ_IDLE;
			drop_set  <= 1'b0;
			len1_q    <= '0;
			set_ready <= 1'b0;
			lost      <= 1'b0;
		end else begin
			state     <= next_state;
			drop_set  <= drop_nxt;
			set_ready <= ready_c;
			lost      <= lost_c;
			if (len_we && id_q == 4'd1)
				len1_q <= pay_cnt;
		end
	end

endmodule

/* hdl/copy_store.sv */
`timescale 1ns/1ps
`include "tmr_rx_cfg.svh"

module copy_store (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   wr_en,
	input  logic [1:0]             wr_copy,
	input  logic [`TMR_ADDR_W-1:0] wr_addr,
	input  logic [7:0]             wr_data,
	input  logic                   len_we,
	input  logic [1:0]             len_copy,
	input  logic [`TMR_ADDR_W-1:0] len_val,
	input  logic [`TMR_ADDR_W-1:0] rd_addr,
	output logic [7:0]             rd_data1,
	output logic [7:0]             rd_data2,
	output logic [7:0]             rd_data3,
	output logic [`TMR_ADDR_W-1:0] len1
);

	// ==================================================================
	// one byte buffer per copy, write port from the producer
	// ==================================================================

	for (genvar g = 0; g < 3; g++) begin : g_copy
		logic [7:0] mem [0:`TMR_MAX_LEN-1];
		logic [7:0] q; // registered read

		always_ff @(posedge clk) begin
			if (wr_en && wr_copy == 2'(g + 1))
				mem[wr_addr] <= wr_data;
			q <= mem[rd_addr];
		end
	end

	assign rd_data1 = g_copy[0].q;
	assign rd_data2 = g_copy[1].q;
	assign rd_data3 = g_copy[2].q;

	// copies 2 and 3 only pass the producer at this same length
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			len1 <= '0;
		else if (len_we && len_copy == 2'd1)
			len1 <= len_val;
	end

endmodule

/* hdl/vote_sender.sv */
`timescale 1ns/1ps
`include "tmr_rx_cfg.svh"

module vote_sender import tmr_rx_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   set_ready,
	input  logic [7:0]             rd_data1,
	input  logic [7:0]             rd_data2,
	input  logic [7:0]             rd_data3,
	input  logic [`TMR_ADDR_W-1:0] len1,
	output logic [`TMR_ADDR_W-1:0] rd_addr,
	output logic                   busy,
	output logic [7:0]             out_data,
	output logic                   out_valid,
	output logic                   out_last,
	output vote_e                  out_flag
);

	localparam int AW = `TMR_ADDR_W;

	logic [AW-1:0] len_q;     // payload length of the set
	logic          rd_act;    // rd_addr holds a live position
	logic          rd_last_a; // rd_addr is the final position
	logic          dat_vld;   // rd_data valid this cycle
	logic          dat_last;

	logic          e12;
	logic          e13;
	logic          e23;
	logic [7:0]    byte_c;
	vote_e         flag_c;

	// ==================================================================
	// address stage
	// ==================================================================

	assign rd_last_a = (rd_addr == len_q - 1'b1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			len_q   <= '0;
			rd_addr <= '0;
			rd_act  <= 1'b0;
		end else if (set_ready) begin
			len_q   <= len1;
			rd_addr <= '0;
			rd_act  <= 1'b1;
		end else if (rd_act) begin
			if (rd_last_a)
				rd_act <= 1'b0;
			else
				rd_addr <= rd_addr + 1'b1;
		end
	end

	// follows the registered memory read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dat_vld  <= 1'b0;
			dat_last <= 1'b0;
		end else begin
			dat_vld  <= rd_act;
			dat_last <= rd_act && rd_last_a;
		end
	end

	// ==================================================================
	// 2-of-3 vote
	// ==================================================================

	assign e12 = (rd_data1 == rd_data2);
	assign e13 = (rd_data1 == rd_data3);
	assign e23 = (rd_data2 == rd_data3);

	always_comb begin
		if (e12 && e13) begin
			byte_c = rd_data1;
			flag_c = VOTE_ALL;
		end else if (e12 || e13) begin
			byte_c = rd_data1; // copy 1 on the majority side
			flag_c = VOTE_MAJ;
		end else if (e23) begin
			byte_c = rd_data2; // copy 1 is the odd one
			flag_c = VOTE_MAJ;
		end else begin
			byte_c = rd_data1;
			flag_c = VOTE_NONE;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= dat_vld;
			out_last  <= dat_last;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= byte_c;
		out_flag <= flag_c;
	end

	// high from the cycle after set_ready through the last byte
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy <= 1'b0;
		else if (set_ready)
			busy <= 1'b1;
		else if (out_valid && out_last)
			busy <= 1'b0;
	end

endmodule

/* hdl/tmr_rx_top.sv */
`timescale 1ns/1ps
`include "tmr_rx_cfg.svh"

module tmr_rx_top import tmr_rx_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rx_en,
	input  logic [7:0] rx_data,
	output logic [7:0] out_data,
	output logic       out_valid,
	output logic       out_last,
	output vote_e      out_flag,
	output logic       lost
);

	// producer to store
	logic                   wr_en;
	logic [1:0]             wr_copy;
	logic [`TMR_ADDR_W-1:0] wr_addr;
	logic [7:0]             wr_data;
	logic                   len_we;
	logic [1:0]             len_copy;
	logic [`TMR_ADDR_W-1:0] len_val;

	// handshake between producer and consumer
	logic                   set_ready;
	logic                   busy;

	// store to consumer
	logic [`TMR_ADDR_W-1:0] rd_addr;
	logic [7:0]             rd_data1;
	logic [7:0]             rd_data2;
	logic [7:0]             rd_data3;
	logic [`TMR_ADDR_W-1:0] len1;

	copy_capture u_capture (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_en     (rx_en),
		.rx_data   (rx_data),
		.busy      (busy),
		.wr_en     (wr_en),
		.wr_copy   (wr_copy),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.len_we    (len_we),
		.len_copy  (len_copy),
		.len_val   (len_val),
		.set_ready (set_ready),
		.lost      (lost)
	);

	copy_store u_store (
		.clk      (clk),
		.arst_n   (arst_n),
		.wr_en    (wr_en),
		.wr_copy  (wr_copy),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.len_we   (len_we),
		.len_copy (len_copy),
		.len_val  (len_val),
		.rd_addr  (rd_addr),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.rd_data3 (rd_data3),
		.len1     (len1)
	);

	vote_sender u_sender (
		.clk       (clk),
		.arst_n    (arst_n),
		.set_ready (set_ready),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.rd_data3  (rd_data3),
		.len1      (len1),
		.rd_addr   (rd_addr),
		.busy      (busy),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_flag  (out_flag)
	);

endmodule

/* dv/tmr_rx_tb.sv */
`timescale 1ns/1ps
`include "tmr_rx_cfg.svh"

module tmr_rx_tb import tmr_rx_pkg::*;;

	localparam int ID_OFF  = `TMR_ID_OFFSET;
	localparam int MAX_LEN = `TMR_MAX_LEN;

	logic       clk;
	logic       arst_n;
	logic       rx_en;
	logic [7:0] rx_data;
	logic [7:0] out_data;
	logic       out_valid;
	logic       out_last;
	vote_e      out_flag;
	logic       lost;

	logic [31:0] seed = 32'hc076_566d;
	logic [7:0]  pay   [1:3][0:255]; // payload to send, per source buffer
	logic [7:0]  mcopy [1:3][0:255]; // copies the model accepted
	logic [10:0] exp_q [$];          // {last, flag, data}
	int          m_state;            // 0 idle, 1 have copy 1, 2 have copies 1 and 2
	int          m_len1;
	bit          m_drop;
	bit          pend_at_id;
	bit          mid_pkt;            // output stream between first and last byte
	int          exp_lost;
	int          lost_cnt;
	int          errors;
	string       cur_test;

	tmr_rx_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_en     (rx_en),
		.rx_data   (rx_data),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_flag  (out_flag),
		.lost      (lost)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_len();
		logic [31:0] r;
		r = lcg_next();
		return 1 + int'(r[23:8] % MAX_LEN);
	endfunction

	// ======================================================================
	// reference model
	// ======================================================================

	task automatic push_votes(input int len);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] v;
		vote_e      f;
		for (int i = 0; i < len; i++) begin
			a = mcopy[1][i];
			b = mcopy[2][i];
			c = mcopy[3][i];
			if (a == b && a == c) begin
				v = a;
				f = VOTE_ALL;
			end else if (a == b || a == c) begin
				v = a;
				f = VOTE_MAJ;
			end else if (b == c) begin
				v = b;
				f = VOTE_MAJ;
			end else begin
				v = a; // no majority, copy 1 wins
				f = VOTE_NONE;
			end
			exp_q.push_back({(i == len - 1), f, v});
		end
	endtask

	task automatic model_pkt(input logic [3:0] id, input int len, input int src);
		if (id == 4'd1) begin
			if (pend_at_id) begin // previous set still going out
				exp_lost++;
				m_drop  = 1'b1;
				m_state = 0;
			end else begin
				m_drop = 1'b0;
				if (m_state != 0)
					exp_lost++;
				for (int i = 0; i < len; i++)
					mcopy[1][i] = pay[src][i];
				m_len1  = len;
				m_state = 1;
			end
		end else if ((id == 4'd2 || id == 4'd3) && !m_drop) begin
			if (id == 4'd2 && m_state == 1 && len == m_len1) begin
				for (int i = 0; i < len; i++)
					mcopy[2][i] = pay[src][i];
				m_state = 2;
			end else if (id == 4'd3 && m_state == 2 && len == m_len1) begin
				for (int i = 0; i < len; i++)
					mcopy[3][i] = pay[src][i];
				push_votes(len);
				m_state = 0;
			end else begin
				exp_lost++;
				m_state = 0;
			end
		end
	endtask

	// ======================================================================
	// stimulus
	// ======================================================================

	task automatic send_pkt(input logic [3:0] id, input int len, input int src);
		logic [31:0] r;
		logic [7:0]  b;
		for (int i = 0; i < ID_OFF + 1 + len; i++) begin
			r = lcg_next();
			if (i < ID_OFF)
				b = r[15:8]; // random header
			else if (i == ID_OFF)
				b = {r[19:16], id};
			else
				b = pay[src][i - ID_OFF - 1];
			@(posedge clk);
			rx_en   <= 1'b1;
			rx_data <= b;
			if (i == ID_OFF) begin
				@(negedge clk);
				pend_at_id = (exp_q.size() != 0); // earlier set not fully out yet
			end
		end
		@(posedge clk);
		rx_en   <= 1'b0;
		rx_data <= 8'h00;
		model_pkt(id, len, src);
		repeat (3) @(posedge clk);
	endtask

	// mode 0 identical, 1 one copy corrupted, 2 some positions all differ
	task automatic fill_set(input int len, input int mode);
		logic [31:0] r;
		for (int i = 0; i < len; i++) begin
			r = lcg_next();
			pay[1][i] = r[15:8];
			pay[2][i] = r[15:8];
			pay[3][i] = r[15:8];
			if (mode == 1 && r[2:0] == 3'd0)
				pay[1 + int'(r[25:24] % 3)][i] = r[15:8] ^ {r[23:17], 1'b1};
			if (mode == 2 && r[1:0] == 2'd0) begin
				pay[2][i] = r[15:8] ^ 8'h01;
				pay[3][i] = r[15:8] ^ 8'h02;
			end
		end
	endtask

	task automatic send_set(input int len);
		send_pkt(4'd1, len, 1);
		send_pkt(4'd2, len, 2);
		send_pkt(4'd3, len, 3);
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (exp_q.size() != 0 && t < 3000) begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout in %s, %0d output bytes never came", cur_test, exp_q.size());
			$display("sim failed");
			$finish;
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic check_lost();
		if (lost_cnt != exp_lost) begin
			$display("Error %s lost strobes expected %0d actual %0d",
				cur_test, exp_lost, lost_cnt);
			errors++;
		end
	endtask

	// whole sets with random length, one after the other
	task automatic voted_sets(input int count, input int mode);
		int len;
		for (int n = 0; n < count; n++) begin
			len = rand_len();
			fill_set(len, mode);
			send_set(len);
			wait_drain();
		end
		check_lost();
	endtask

	// ======================================================================
	// checker
	// ======================================================================

	always @(posedge clk) begin
		if (arst_n && lost)
			lost_cnt++;
		if (arst_n && mid_pkt && !out_valid) begin
			$display("output stream in %s broke off before its last byte", cur_test);
			errors++;
		end
		mid_pkt = arst_n && out_valid && !out_last;
		if (arst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected output byte %h in %s", out_data, cur_test);
				errors++;
			end else begin
				if (out_data != exp_q[0][7:0]) begin
					$display("Error %s data expected %h actual %h",
						cur_test, exp_q[0][7:0], out_data);
					errors++;
				end
				if (out_flag != exp_q[0][9:8]) begin
					$display("Error %s flag expected %0d actual %0d",
						cur_test, exp_q[0][9:8], out_flag);
					errors++;
				end
				if (out_last != exp_q[0][10]) begin
					$display("Error %s last expected %b actual %b",
						cur_test, exp_q[0][10], out_last);
					errors++;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		int          len;
		logic [31:0] r;
		rx_en      = 1'b0;
		rx_data    = 8'h00;
		arst_n     = 1'b0;
		m_state    = 0;
		m_len1     = 0;
		m_drop     = 1'b0;
		pend_at_id = 1'b0;
		exp_lost   = 0;
		lost_cnt   = 0;
		errors     = 0;
		cur_test   = "reset";
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);

		cur_test = "clean";
		voted_sets(3, 0);

		cur_test = "majority";
		voted_sets(3, 1);

		cur_test = "no_majority";
		voted_sets(2, 2);

		// ==================================================================
		// broken sets
		// ==================================================================

		cur_test = "order";
		fill_set(MAX_LEN, 0);
		len = rand_len();
		send_pkt(4'd1, len, 1);
		send_pkt(4'd3, len, 3); // copy 2 skipped
		send_pkt(4'd2, len, 2); // no copy 1 before it
		send_pkt(4'd1, len, 1);
		send_pkt(4'd2, len, 2);
		send_pkt(4'd3, len % MAX_LEN + 1, 3); // length differs from copy 1
		send_pkt(4'd1, len, 1);
		send_pkt(4'd2, len, 2);
		send_set(len); // new copy 1 restarts the set
		wait_drain();
		check_lost();

		cur_test = "ignored_id";
		fill_set(MAX_LEN, 1);
		len = rand_len();
		r   = lcg_next();
		send_pkt(4'd1, len, 1);
		send_pkt(4'd0, rand_len(), 2);
		send_pkt(4'd2, len, 2);
		send_pkt(4'd4 + 4'(r[15:8] % 12), rand_len(), 3);
		send_pkt(4'd3, len, 3);
		wait_drain();
		check_lost();

		// second set starts while the long first one is still going out
		cur_test = "busy_drop";
		fill_set(MAX_LEN, 0);
		send_set(MAX_LEN);
		send_set(rand_len());
		wait_drain();
		len = rand_len();
		fill_set(len, 0);
		send_set(len);
		wait_drain();
		check_lost();

		$display("%0d errors, %0d lost strobes, %0d expected", errors, lost_cnt, exp_lost);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+hdl
hdl/tmr_rx_pkg.sv
hdl/copy_capture.sv
hdl/copy_store.sv
hdl/vote_sender.sv
hdl/tmr_rx_top.sv
dv/tmr_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the TMR receive testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tmr_rx_tb -o sim_tmr_rx

out=$(./obj_dir/sim_tmr_rx)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
